// File: rtl/apb_pkg.sv
package apb_pkg;

    localparam int APB_ADDR_W = 32;
    localparam int APB_DATA_W = 32;

    typedef struct packed {
        logic                  psel;
        logic                  penable;
        logic                  pwrite;
        logic [APB_ADDR_W-1:0] paddr;
        logic [APB_DATA_W-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [APB_DATA_W-1:0] prdata;
        logic                  pready;
        logic                  pslverr;
    } apb_rsp_t;

    typedef enum logic [1:0] {
        APB_IDLE,
        APB_READ,
        APB_WRITE
    } apb_op_e;

endpackage

// File: rtl/uart_cfg_pkg.sv
package uart_cfg_pkg;

    localparam int UART_DIV_W      = 16;
    localparam int UART_FIFO_DEPTH = 16;

    localparam logic [UART_DIV_W-1:0] UART_DIV_RST = 16'd15;

    // Register map, byte addresses.
    localparam logic [7:0] ADDR_DATA    = 8'h00;
    localparam logic [7:0] ADDR_STATUS  = 8'h04;
    localparam logic [7:0] ADDR_CONTROL = 8'h08;
    localparam logic [7:0] ADDR_CLK_DIV = 8'h0C;

    typedef struct packed {
        logic parity_odd;   // Bit 3.
        logic parity_even;  // Bit 2, wins over odd.
        logic rx_flush;     // Bit 1.
        logic tx_flush;     // Bit 0.
    } uart_ctrl_t;

    typedef struct packed {
        logic parity_err;     // Bit 3, sticky.
        logic tx_busy;        // Bit 2.
        logic tx_fifo_full;   // Bit 1.
        logic rx_fifo_empty;  // Bit 0.
    } uart_status_t;

    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } uart_byte_t;

    typedef enum logic [2:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_PARITY,
        TX_STOP
    } tx_state_e;

    typedef enum logic [2:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_PARITY,
        RX_STOP
    } rx_state_e;

endpackage

// File: rtl/uart_fifo.sv
`timescale 1ns/1ps

module uart_fifo #(
    parameter int DEPTH = 16
) (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     flush_i,
    input  uart_cfg_pkg::uart_byte_t in_i,
    output logic                     in_ready_o,
    output uart_cfg_pkg::uart_byte_t out_o,
    input  logic                     out_ready_i
);

    import uart_cfg_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [7:0]       mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             push;
    logic             pop;

    // Full still accepts when the head leaves in the same cycle.
    assign in_ready_o  = (count_q != CNT_W'(DEPTH)) || out_ready_i;
    assign out_o.valid = count_q != '0;
    assign out_o.data  = mem[rd_ptr_q];

    assign push = in_i.valid && in_ready_o;
    assign pop  = out_o.valid && out_ready_i;

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wr_ptr_q] <= in_i.data;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

endmodule

// File: rtl/uart_tx.sv
`timescale 1ns/1ps

module uart_tx (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    input  uart_cfg_pkg::uart_byte_t            in_i,
    output logic                                in_ready_o,
    input  uart_cfg_pkg::uart_ctrl_t            ctrl_i,
    input  logic [uart_cfg_pkg::UART_DIV_W-1:0] clk_div_i,
    output logic                                busy_o,
    output logic                                uart_tx_o
);

    import uart_cfg_pkg::*;

    tx_state_e             state_q;
    logic [UART_DIV_W-1:0] cnt_q;
    logic [2:0]            bit_idx_q;
    logic [7:0]            shift_q;
    logic                  par_q;
    logic                  par_en_q;
    logic                  tx_q;
    logic                  bit_end;

    assign bit_end    = cnt_q == clk_div_i;
    assign in_ready_o = state_q == TX_IDLE;
    assign busy_o     = state_q != TX_IDLE;
    assign uart_tx_o  = tx_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q   <= TX_IDLE;
            cnt_q     <= '0;
            bit_idx_q <= '0;
            par_en_q  <= 1'b0;
            tx_q      <= 1'b1;
        end else begin
            cnt_q <= bit_end ? '0 : cnt_q + 1'b1;
            case (state_q)
                TX_IDLE: begin
                    cnt_q <= '0;
                    tx_q  <= 1'b1;
                    if (in_i.valid) begin
                        shift_q  <= in_i.data;
                        // Even wins when both modes are set.
                        par_q    <= ctrl_i.parity_even ? ^in_i.data : ~^in_i.data;
                        par_en_q <= ctrl_i.parity_even | ctrl_i.parity_odd;
                        tx_q     <= 1'b0;  // Start bit.
                        state_q  <= TX_START;
                    end
                end
                TX_START: if (bit_end) begin
                    tx_q      <= shift_q[0];
                    bit_idx_q <= '0;
                    state_q   <= TX_DATA;
                end
                TX_DATA: if (bit_end) begin
                    shift_q   <= shift_q >> 1;
                    bit_idx_q <= bit_idx_q + 1'b1;
                    tx_q      <= shift_q[1];
                    if (bit_idx_q == 3'd7) begin
                        tx_q    <= par_en_q ? par_q : 1'b1;
                        state_q <= par_en_q ? TX_PARITY : TX_STOP;
                    end
                end
                TX_PARITY: if (bit_end) begin
                    tx_q    <= 1'b1;
                    state_q <= TX_STOP;
                end
                TX_STOP: if (bit_end) begin
                    state_q <= TX_IDLE;
                end
                default: state_q <= TX_IDLE;
            endcase
        end
    end

endmodule

// File: rtl/uart_rx.sv
`timescale 1ns/1ps

module uart_rx (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    input  logic                                uart_rx_i,
    input  uart_cfg_pkg::uart_ctrl_t            ctrl_i,
    input  logic [uart_cfg_pkg::UART_DIV_W-1:0] clk_div_i,
    output uart_cfg_pkg::uart_byte_t            out_o,
    output logic                                parity_err_o
);

    import uart_cfg_pkg::*;

    rx_state_e             state_q;
    logic                  rx_s1_q;
    logic                  rx_s2_q;
    logic                  rx_d_q;
    logic [UART_DIV_W-1:0] cnt_q;
    logic [2:0]            bit_idx_q;
    logic [7:0]            shift_q;
    logic                  par_en_q;
    logic                  par_even_q;
    logic                  par_exp;
    logic                  bit_end;
    logic                  half_end;

    assign bit_end  = cnt_q == clk_div_i;
    assign half_end = cnt_q == (clk_div_i >> 1);
    assign par_exp  = par_even_q ? ^shift_q : ~^shift_q;

    // Both outputs are decided at the sample point itself.
    assign out_o.valid  = (state_q == RX_STOP) && bit_end && rx_s2_q;
    assign out_o.data   = shift_q;
    assign parity_err_o = (state_q == RX_PARITY) && bit_end && (rx_s2_q != par_exp);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rx_s1_q <= 1'b1;
            rx_s2_q <= 1'b1;
            rx_d_q  <= 1'b1;
        end else begin
            rx_s1_q <= uart_rx_i;  // Two-flop synchronizer.
            rx_s2_q <= rx_s1_q;
            rx_d_q  <= rx_s2_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q    <= RX_IDLE;
            cnt_q      <= '0;
            bit_idx_q  <= '0;
            par_en_q   <= 1'b0;
            par_even_q <= 1'b0;
        end else begin
            cnt_q <= bit_end ? '0 : cnt_q + 1'b1;
            case (state_q)
                RX_IDLE: begin
                    cnt_q <= '0;
                    if (rx_d_q && !rx_s2_q) begin
                        par_en_q   <= ctrl_i.parity_even | ctrl_i.parity_odd;
                        par_even_q <= ctrl_i.parity_even;
                        state_q    <= RX_START;
                    end
                end
                RX_START: if (half_end) begin
                    // A glitch no longer low at mid-start is ignored.
                    cnt_q     <= '0;
                    bit_idx_q <= '0;
                    state_q   <= rx_s2_q ? RX_IDLE : RX_DATA;
                end
                RX_DATA: if (bit_end) begin
                    shift_q   <= {rx_s2_q, shift_q[7:1]};  // LSB first.
                    bit_idx_q <= bit_idx_q + 1'b1;
                    if (bit_idx_q == 3'd7) begin
                        state_q <= par_en_q ? RX_PARITY : RX_STOP;
                    end
                end
                RX_PARITY: if (bit_end) begin
                    state_q <= RX_STOP;
                end
                RX_STOP: if (bit_end) begin
                    state_q <= RX_IDLE;
                end
                default: state_q <= RX_IDLE;
            endcase
        end
    end

endmodule

// File: rtl/uart_regs.sv
`timescale 1ns/1ps

module uart_regs (
    input  logic                                    clk_i,
    input  logic                                    rst_n_i,
    input  apb_pkg::apb_req_t                       apb_req_i,
    output apb_pkg::apb_rsp_t                       apb_rsp_o,
    input  logic                                    tx_ready_i,
    input  uart_cfg_pkg::uart_byte_t                rx_pop_i,
    input  logic                                    tx_busy_i,
    input  logic                                    parity_err_i,
    output uart_cfg_pkg::uart_byte_t                tx_push_o,
    output logic                                    rx_pop_ready_o,
    output uart_cfg_pkg::uart_ctrl_t                ctrl_o,
    output logic [uart_cfg_pkg::UART_DIV_W-1:0]     clk_div_o
);

    import apb_pkg::*;
    import uart_cfg_pkg::*;

    apb_op_e               op;
    logic                  hit_data;
    logic                  hit_status;
    logic                  hit_control;
    logic                  hit_clk_div;
    logic                  hit_any;
    uart_ctrl_t            ctrl_q;
    logic [UART_DIV_W-1:0] clk_div_q;
    logic                  parity_err_q;
    uart_status_t          status;
    logic [APB_DATA_W-1:0] rdata;

    // Only the access phase does anything.
    always_comb begin
        if (!apb_req_i.psel || !apb_req_i.penable) begin
            op = APB_IDLE;
        end else if (apb_req_i.pwrite) begin
            op = APB_WRITE;
        end else begin
            op = APB_READ;
        end
    end

    assign hit_data    = apb_req_i.paddr == APB_ADDR_W'(ADDR_DATA);
    assign hit_status  = apb_req_i.paddr == APB_ADDR_W'(ADDR_STATUS);
    assign hit_control = apb_req_i.paddr == APB_ADDR_W'(ADDR_CONTROL);
    assign hit_clk_div = apb_req_i.paddr == APB_ADDR_W'(ADDR_CLK_DIV);
    assign hit_any     = hit_data | hit_status | hit_control | hit_clk_div;

    assign status.rx_fifo_empty = ~rx_pop_i.valid;
    assign status.tx_fifo_full  = ~tx_ready_i;
    assign status.tx_busy       = tx_busy_i;
    assign status.parity_err    = parity_err_q;

    always_comb begin
        rdata = '0;
        if (hit_data && rx_pop_i.valid) begin
            rdata = APB_DATA_W'(rx_pop_i.data);
        end else if (hit_status) begin
            rdata = APB_DATA_W'(status);
        end else if (hit_control) begin
            rdata = APB_DATA_W'(ctrl_q);
        end else if (hit_clk_div) begin
            rdata = APB_DATA_W'(clk_div_q);
        end
    end

    assign apb_rsp_o.prdata  = (op == APB_READ) ? rdata : '0;
    assign apb_rsp_o.pready  = 1'b1;
    assign apb_rsp_o.pslverr = (op != APB_IDLE) && !hit_any;

    // One-cycle strobes toward the FIFOs.
    assign tx_push_o.valid = (op == APB_WRITE) && hit_data;
    assign tx_push_o.data  = apb_req_i.pwdata[7:0];
    assign rx_pop_ready_o  = (op == APB_READ) && hit_data;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ctrl_q       <= '0;
            clk_div_q    <= UART_DIV_RST;
            parity_err_q <= 1'b0;
        end else begin
            ctrl_q.tx_flush <= 1'b0;  // Self-clearing.
            ctrl_q.rx_flush <= 1'b0;
            if (op == APB_WRITE && hit_control) begin
                ctrl_q <= uart_ctrl_t'(apb_req_i.pwdata[$bits(uart_ctrl_t)-1:0]);
            end
            if (op == APB_WRITE && hit_clk_div) begin
                clk_div_q <= apb_req_i.pwdata[UART_DIV_W-1:0];
            end
            // A new error wins over the clear on read.
            if (parity_err_i) begin
                parity_err_q <= 1'b1;
            end else if (op == APB_READ && hit_status) begin
                parity_err_q <= 1'b0;
            end
        end
    end

    assign ctrl_o    = ctrl_q;
    assign clk_div_o = clk_div_q;

endmodule

// File: rtl/apb_uart.sv
`timescale 1ns/1ps

module apb_uart #(
    parameter int FIFO_DEPTH = uart_cfg_pkg::UART_FIFO_DEPTH
) (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  apb_pkg::apb_req_t apb_req_i,
    output apb_pkg::apb_rsp_t apb_rsp_o,
    input  logic              uart_rx_i,
    output logic              uart_tx_o
);

    import uart_cfg_pkg::*;

    uart_byte_t            tx_push;
    logic                  tx_push_ready;
    uart_byte_t            tx_head;
    logic                  tx_head_ready;
    logic                  tx_busy;
    uart_byte_t            rx_byte;
    uart_byte_t            rx_head;
    logic                  rx_pop_ready;
    logic                  parity_err;
    uart_ctrl_t            ctrl;
    logic [UART_DIV_W-1:0] clk_div;

    uart_regs i_uart_regs (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .apb_req_i     (apb_req_i),
        .apb_rsp_o     (apb_rsp_o),
        .tx_ready_i    (tx_push_ready),
        .rx_pop_i      (rx_head),
        .tx_busy_i     (tx_busy),
        .parity_err_i  (parity_err),
        .tx_push_o     (tx_push),
        .rx_pop_ready_o(rx_pop_ready),
        .ctrl_o        (ctrl),
        .clk_div_o     (clk_div)
    );

    uart_fifo #(
        .DEPTH(FIFO_DEPTH)
    ) i_fifo_tx (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .flush_i    (ctrl.tx_flush),
        .in_i       (tx_push),
        .in_ready_o (tx_push_ready),
        .out_o      (tx_head),
        .out_ready_i(tx_head_ready)
    );

    uart_tx i_uart_tx (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .in_i      (tx_head),
        .in_ready_o(tx_head_ready),
        .ctrl_i    (ctrl),
        .clk_div_i (clk_div),
        .busy_o    (tx_busy),
        .uart_tx_o (uart_tx_o)
    );

    uart_rx i_uart_rx (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .uart_rx_i   (uart_rx_i),
        .ctrl_i      (ctrl),
        .clk_div_i   (clk_div),
        .out_o       (rx_byte),
        .parity_err_o(parity_err)
    );

    // No back-pressure toward the line, a full FIFO drops the byte.
    uart_fifo #(
        .DEPTH(FIFO_DEPTH)
    ) i_fifo_rx (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .flush_i    (ctrl.rx_flush),
        .in_i       (rx_byte),
        .in_ready_o (),
        .out_o      (rx_head),
        .out_ready_i(rx_pop_ready)
    );

endmodule

// File: test/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);

    localparam int HALF_PERIOD  = 50;
    localparam int RESET_CYCLES = 5;

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    // Released just after the last reset edge.
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #10;
        rst_n_o = 1'b1;
    end

endmodule

// File: test/tb_apb_uart.sv
`timescale 1ns/1ps

module tb_apb_uart;

    import apb_pkg::*;
    import uart_cfg_pkg::*;

    localparam int          NUM_FRAMES   = 22;
    localparam int          FRAME_CYCLES = 11 * 8;  // Parity frame at divider 7.
    localparam int          CYCLE_LIMIT  = (3 * NUM_FRAMES * FRAME_CYCLES) / 2 + 2000;
    localparam logic [31:0] RAND_SEED    = 32'hc0d3b426;
    localparam int          DRIVE_DELAY  = 10;

    typedef struct packed {
        logic       par_even;
        logic       par_odd;
        logic [7:0] data;
    } tx_exp_t;

    typedef struct packed {
        logic [3:0]  nbits;
        logic        parity;
        logic [10:0] bits;  // Bit 0 is the start bit.
    } frame_t;

    logic     clk;
    logic     rst_n;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;
    logic     uart_rx;
    logic     uart_tx;
    logic     loopback;
    logic     bb_line;
    int       cur_div      = 15;
    int       cycle_cnt    = 0;
    int       checks       = 0;
    int       errors       = 0;
    int       tests_failed = 0;
    int       frames_sent  = 0;
    int       frames_seen  = 0;
    tx_exp_t  exp_q[$];

    assign uart_rx = loopback ? uart_tx : bb_line;

    tb_clock_gen i_clock_gen (
        .clk_o  (clk),
        .rst_n_o(rst_n)
    );

    apb_uart uut (
        .clk_i    (clk),
        .rst_n_i  (rst_n),
        .apb_req_i(apb_req),
        .apb_rsp_o(apb_rsp),
        .uart_rx_i(uart_rx),
        .uart_tx_o(uart_tx)
    );

    // Expected line frame for one byte.
    function automatic frame_t frame_bits(input logic [7:0] data, input logic par_even,
                                          input logic par_odd);
        frame_t f;
        int     ones;
        ones = 0;
        for (int i = 0; i < 8; i++) begin
            ones += data[i];
        end
        f.bits      = '1;
        f.bits[0]   = 1'b0;
        f.bits[8:1] = data;
        f.parity    = par_even ? ones[0] : !ones[0];  // Even wins.
        if (par_even || par_odd) begin
            f.bits[9] = f.parity;
            f.nbits   = 4'd11;
        end else begin
            f.nbits = 4'd10;
        end
        return f;
    endfunction

    task automatic check(input logic [31:0] expected, input logic [31:0] actual,
                         input string msg);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED at %0t ns: %s, expected 0x%0h, got 0x%0h",
                     $time, msg, expected, actual);
        end
    endtask

    task automatic apb_access(input logic is_write, input logic [7:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        @(posedge clk);
        #DRIVE_DELAY;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = is_write;
        apb_req.paddr   = 32'(addr);
        apb_req.pwdata  = wdata;
        @(posedge clk);
        #DRIVE_DELAY;
        apb_req.penable = 1'b1;
        @(negedge clk);  // Access cycle.
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        check(1, apb_rsp.pready, $sformatf("pready in access cycle at 0x%0h", addr));
        @(posedge clk);
        #DRIVE_DELAY;
        apb_req = '0;
    endtask

    task automatic reg_write(input logic [7:0] addr, input logic [31:0] wdata);
        logic [31:0] rdata;
        logic        err;
        apb_access(1'b1, addr, wdata, rdata, err);
        check(0, err, $sformatf("pslverr on write to 0x%0h", addr));
    endtask

    task automatic reg_read(input logic [7:0] addr, output logic [31:0] rdata);
        logic err;
        apb_access(1'b0, addr, 32'h0, rdata, err);
        check(0, err, $sformatf("pslverr on read of 0x%0h", addr));
    endtask

    task automatic set_div(input int div);
        reg_write(ADDR_CLK_DIV, 32'(div));
        cur_div = div;
    endtask

    task automatic send_byte(input logic [7:0] data, input logic par_even, input logic par_odd);
        exp_q.push_back({par_even, par_odd, data});
        frames_sent++;
        reg_write(ADDR_DATA, 32'(data));
    endtask

    task automatic wait_all_frames();
        while (frames_seen < frames_sent) begin
            @(posedge clk);
        end
    endtask

    task automatic wait_rx_ready(output logic [31:0] status);
        status = 32'h1;
        while (status[0]) begin
            reg_read(ADDR_STATUS, status);
        end
    endtask

    task automatic wait_tx_idle();
        logic [31:0] status;
        status = 32'h4;
        while (status[2]) begin
            reg_read(ADDR_STATUS, status);
        end
    endtask

    // Drives one frame onto uart_rx_i with an optional flipped parity bit.
    task automatic send_frame(input logic [7:0] data, input logic par_even,
                              input logic par_odd, input logic bad_parity);
        frame_t f;
        f = frame_bits(data, par_even, par_odd);
        if (bad_parity) begin
            f.bits[9] = ~f.bits[9];
        end
        @(posedge clk);
        #DRIVE_DELAY;
        for (int i = 0; i < f.nbits; i++) begin
            bb_line = f.bits[i];
            repeat (cur_div + 1) @(posedge clk);
            #DRIVE_DELAY;
        end
        bb_line = 1'b1;
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            $display("%s: pass", name);
        end else begin
            tests_failed++;
            $display("%s: fail, %0d errors", name, errors - errors_before);
        end
    endtask

    // Captures every frame on uart_tx_o and compares it with the reference.
    initial begin : line_monitor
        logic    prev;
        logic    first_lvl;
        logic    stable;
        int      d;
        tx_exp_t e;
        frame_t  want;
        frame_t  got;
        prev = 1'b1;
        forever begin
            @(negedge clk);
            if (prev === 1'b1 && uart_tx === 1'b0) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("unexpected frame started on uart_tx_o at %0t ns", $time);
                end else begin
                    e    = exp_q.pop_front();
                    want = frame_bits(e.data, e.par_even, e.par_odd);
                    got  = '1;
                    d    = cur_div + 1;
                    for (int idx = 0; idx < want.nbits * d; idx++) begin
                        if (idx > 0) begin
                            @(negedge clk);
                        end
                        if (idx % d == 0) begin
                            first_lvl = uart_tx;
                            stable    = 1'b1;
                        end else if (uart_tx !== first_lvl) begin
                            stable = 1'b0;
                        end
                        if (idx % d == d / 2) begin
                            got.bits[idx / d] = uart_tx;  // Mid-bit sample.
                        end
                        if (idx % d == d - 1) begin
                            check(1, stable, $sformatf("bit %0d held clk_div+1 cycles", idx / d));
                        end
                    end
                    check(32'(want.bits), 32'(got.bits), $sformatf("frame of 0x%0h", e.data));
                    if (want.nbits == 4'd11) begin
                        check(want.parity, got.bits[9], $sformatf("parity of 0x%0h", e.data));
                    end
                    frames_seen++;
                end
            end
            prev = uart_tx;
        end
    end

    initial begin : watchdog
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: simulation did not finish");
        $display("Something failed");
        $finish;
    end

    initial begin : main
        logic [31:0] rd;
        logic [31:0] st;
        logic        err;
        logic [7:0]  b;
        logic [7:0]  sent[$];
        int          mark;
        int unsigned rnd;
        apb_req  = '0;
        bb_line  = 1'b1;
        loopback = 1'b0;
        rnd      = $urandom(RAND_SEED);
        @(posedge rst_n);

        mark = errors;
        check(1, uart_tx, "uart_tx_o idle after reset");
        reg_read(ADDR_STATUS, rd);
        check(32'h1, rd, "STATUS after reset");
        reg_read(ADDR_CLK_DIV, rd);
        check(32'd15, rd, "CLK_DIV after reset");
        reg_read(ADDR_CONTROL, rd);
        check(32'h0, rd, "CONTROL after reset");
        set_div(7);
        reg_read(ADDR_CLK_DIV, rd);
        check(32'd7, rd, "CLK_DIV readback");
        reg_write(ADDR_CONTROL, 32'hB);  // Odd parity and both flushes.
        reg_read(ADDR_CONTROL, rd);
        check(32'h8, rd, "CONTROL readback with flush bits cleared");
        apb_access(1'b1, 8'h10, 32'h3, rd, err);
        check(1, err, "pslverr on write to 0x10");
        apb_access(1'b0, 8'h10, 32'h0, rd, err);
        check(1, err, "pslverr on read of 0x10");
        check(0, rd, "read data of 0x10");
        reg_read(ADDR_CLK_DIV, rd);
        check(32'd7, rd, "CLK_DIV after access to 0x10");
        reg_read(ADDR_CONTROL, rd);
        check(32'h8, rd, "CONTROL after access to 0x10");
        report_test("test 1 reset and registers", mark);

        mark = errors;
        for (int mode = 0; mode < 3; mode++) begin
            reg_write(ADDR_CONTROL, (mode == 1) ? 32'h4 : (mode == 2) ? 32'h8 : 32'h0);
            for (int n = 0; n < 4; n++) begin
                b = 8'($urandom);
                send_byte(b, mode == 1, mode == 2);
            end
            wait_all_frames();
        end
        report_test("test 2 transmit framing", mark);

        mark = errors;
        loopback = 1'b1;
        reg_write(ADDR_CONTROL, 32'h4);
        for (int n = 0; n < 8; n++) begin
            b = 8'($urandom);
            sent.push_back(b);
            send_byte(b, 1'b1, 1'b0);
        end
        for (int n = 0; n < 8; n++) begin
            wait_rx_ready(st);
            check(0, st[3], "parity_err during loopback");
            reg_read(ADDR_DATA, rd);
            check(32'(sent[n]), rd, $sformatf("loopback byte %0d", n));
        end
        wait_all_frames();
        loopback = 1'b0;
        report_test("test 3 loopback", mark);

        mark = errors;
        b = 8'($urandom);
        send_frame(b, 1'b1, 1'b0, 1'b1);
        reg_read(ADDR_STATUS, st);
        check(1, st[3], "parity_err after bad frame");
        check(0, st[0], "rx_fifo_empty after bad frame");
        reg_read(ADDR_STATUS, st);
        check(0, st[3], "parity_err cleared by STATUS read");
        reg_read(ADDR_DATA, rd);
        check(32'(b), rd, "byte of bad parity frame");
        report_test("test 4 parity error", mark);

        mark = errors;
        reg_write(ADDR_CONTROL, 32'h0);
        // Only the first byte reaches the line. The rest are flushed or dropped.
        for (int n = 0; n < UART_FIFO_DEPTH + 2; n++) begin
            b = 8'($urandom);
            if (n == 0) begin
                send_byte(b, 1'b0, 1'b0);
            end else begin
                reg_write(ADDR_DATA, 32'(b));
            end
        end
        reg_read(ADDR_STATUS, st);
        check(1, st[1], "tx_fifo_full after back to back writes");
        check(1, st[2], "tx_busy during the first frame");
        reg_write(ADDR_CONTROL, 32'h1);
        wait_tx_idle();
        repeat (3 * 10 * (cur_div + 1)) @(posedge clk);
        check(frames_sent, frames_seen, "frames on the line after flush");
        check(0, exp_q.size(), "frames still expected after flush");
        reg_read(ADDR_STATUS, st);
        check(32'h1, st, "STATUS after flush");
        reg_read(ADDR_DATA, rd);
        check(0, rd, "DATA read with empty RX FIFO");
        report_test("test 5 FIFO full and flush", mark);

        $display("tests: 5, failed: %0d, checks: %0d, errors: %0d",
                 tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: apb_uart.f
rtl/apb_pkg.sv
rtl/uart_cfg_pkg.sv
rtl/uart_fifo.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/uart_regs.sv
rtl/apb_uart.sv
test/tb_clock_gen.sv
test/tb_apb_uart.sv

// File: Bender.yml
package:
  name: apb_uart

sources:
  - files:
      - rtl/apb_pkg.sv
      - rtl/uart_cfg_pkg.sv
      - rtl/uart_fifo.sv
      - rtl/uart_tx.sv
      - rtl/uart_rx.sv
      - rtl/uart_regs.sv
      - rtl/apb_uart.sv
  - target: test
    files:
      - test/tb_clock_gen.sv
      - test/tb_apb_uart.sv
